// File: dv/core_port_assert.sv
////////////////////////////////////////
// Concurrent checks on the core port glue
// and their bind into the top level
////////////////////////////////////////
`timescale 1ns/1ps

module core_port_assert (
  input logic                       clk,
  input logic                       rst,
  input logic                       ctrl_valid,
  input core_port_pkg::desc_t       ctrl_data,
  input logic                       core_reset,
  input logic                       send_desc_valid,
  input core_port_pkg::desc_t       send_desc,
  input logic                       send_desc_ready,
  input core_port_pkg::core_msg_t   msg_in,
  input logic                       msg_in_valid,
  input logic                       msg_wr_valid,
  input core_port_pkg::mem_wr_cmd_t wr_cmd,
  input logic                       wr_ready,
  input core_port_pkg::mem_rd_cmd_t rd_cmd,
  input logic                       rd_ready,
  input logic                       rd_resp_valid,
  input logic                       rd_resp_ready,
  input core_port_pkg::dmem_port_t  dmem,
  input core_port_pkg::imem_port_t  imem
);

  int   fail_count = 0;
  logic is_cmd;
  logic both_req;

  // Marker byte in the top of a valid control word
  assign is_cmd = ctrl_valid && (ctrl_data[63:56] == core_port_pkg::RESET_CMD_BYTE);

  // DMEM write and DMEM read both pending, port free for DMA traffic
  assign both_req = wr_cmd.en && !wr_cmd.addr[15] && rd_cmd.en && !msg_wr_valid &&
                    !(rd_resp_valid && !rd_resp_ready);

  function automatic void note_fail(input string what);
    $error("%s", what);
    fail_count++;
  endfunction

  ////////////////////////////////////////
  // Reset and control path
  ////////////////////////////////////////

  a_reset_state: assert property (@(posedge clk) rst |=> core_reset && !send_desc_valid &&
                                  !rd_resp_valid && !dmem.en && (dmem.wen == '0))
    else note_fail("Outputs not in reset state after rst");
  a_reset_cmd: assert property (@(posedge clk) disable iff (rst)
                                is_cmd |=> core_reset == $past(ctrl_data[0]))
    else note_fail("core_reset did not follow bit 0 of a reset command");
  a_no_cmd_out: assert property (@(posedge clk) disable iff (rst)
                                 send_desc_valid |->
                                 send_desc[63:56] != core_port_pkg::RESET_CMD_BYTE)
    else note_fail("Reset command word appeared on send_desc");
  // Stalled descriptor must not move
  a_desc_hold: assert property (@(posedge clk) disable iff (rst)
                                send_desc_valid && !send_desc_ready |=>
                                send_desc_valid && $stable(send_desc))
    else note_fail("send_desc changed while send_desc_ready was low");

  ////////////////////////////////////////
  // Memory path
  ////////////////////////////////////////

  // Message lands one cycle later, in the half picked by address bit 2
  a_msg_write: assert property (@(posedge clk) disable iff (rst)
    msg_in_valid |=> dmem.en && (dmem.addr == {1'b0, $past(msg_in.addr)}) &&
      (dmem.wen == ($past(msg_in.addr[2]) ? {$past(msg_in.strb), 4'h0}
                                          : {4'h0, $past(msg_in.strb)})) &&
      (dmem.wr_data == ($past(msg_in.addr[2]) ? {$past(msg_in.data), 32'h0}
                                              : {32'h0, $past(msg_in.data)})))
    else note_fail("Broadcast message write wrong on the dmem port");
  a_msg_blocks: assert property (@(posedge clk) disable iff (rst)
                                 msg_in_valid |=> !rd_ready &&
                                 !(wr_ready && wr_cmd.en && !wr_cmd.addr[15]))
    else note_fail("DMA command accepted during a message write");
  a_imem_split: assert property (@(posedge clk) disable iff (rst)
    wr_cmd.en && wr_cmd.addr[15] |-> wr_ready && (imem.wen == wr_cmd.strb) &&
      (imem.addr == {1'b0, wr_cmd.addr[14:0]}) && (imem.wr_data == wr_cmd.data) &&
      (msg_wr_valid || (dmem.wen == '0)))
    else note_fail("IMEM write not passed straight to the imem port");
  a_no_rw: assert property (@(posedge clk) disable iff (rst) !(dmem.ren && (dmem.wen != '0)))
    else note_fail("dmem read and write in the same cycle");
  a_alternate: assert property (@(posedge clk) disable iff (rst)
                                both_req && $past(both_req) |-> dmem.ren != $past(dmem.ren))
    else note_fail("DMEM reads and writes did not alternate");

  ////////////////////////////////////////
  // Read response
  ////////////////////////////////////////

  a_resp_after_read: assert property (@(posedge clk) disable iff (rst) rd_ready |=> rd_resp_valid)
    else note_fail("rd_resp_valid missing one cycle after an accepted read");
  a_reject: assert property (@(posedge clk) disable iff (rst)
                             rd_resp_valid && !rd_resp_ready |-> !rd_ready ##1 rd_resp_valid)
    else note_fail("Read response under back-pressure not held");

endmodule

bind core_port_top core_port_assert u_assert (.*);

// File: dv/tb_core_port.sv
////////////////////////////////////////
// Testbench for the core port glue with
// DMEM model and descriptor scoreboard
////////////////////////////////////////
`timescale 1ns/1ps

module tb_core_port;

  localparam int TIMEOUT = 200;

  logic                       clk;
  logic                       rst;
  logic                       ctrl_valid;
  core_port_pkg::desc_t       ctrl_data;
  logic                       ctrl_ready;
  logic                       core_reset;
  logic                       core_desc_valid;
  core_port_pkg::desc_t       core_desc;
  logic                       core_desc_ready;
  logic                       send_desc_valid;
  core_port_pkg::desc_t       send_desc;
  logic                       send_desc_ready;
  core_port_pkg::core_msg_t   msg_in;
  logic                       msg_in_valid;
  core_port_pkg::mem_wr_cmd_t wr_cmd;
  logic                       wr_ready;
  core_port_pkg::mem_rd_cmd_t rd_cmd;
  logic                       rd_ready;
  logic                       rd_resp_valid;
  logic                       rd_resp_ready;
  core_port_pkg::dmem_port_t  dmem;
  core_port_pkg::imem_port_t  imem;

  integer seed = 58557;
  int     errors = 0;
  int     timeouts = 0;
  logic   resp_rand = 1'b0;
  logic   msg_pend = 1'b0;
  core_port_pkg::core_msg_t msg_reg;
  core_port_pkg::data_t     rd_data;
  // Expected send descriptors per source and expected read data
  core_port_pkg::desc_t     exp_ctrl [$];
  core_port_pkg::desc_t     exp_core [$];
  core_port_pkg::data_t     exp_rd [$];
  // DMEM model and the contents the stimulus intends, both 16 words
  core_port_pkg::data_t     dmem_model [16];
  core_port_pkg::data_t     shadow [16];

  core_port_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic core_port_pkg::data_t fill_word(input int idx);
    return {16'hC0DE, 16'(idx), ~16'(idx), 16'(idx * 7 + 3)};
  endfunction

  // Byte-lane merge under a strobe
  function automatic core_port_pkg::data_t merge_bytes(input core_port_pkg::data_t old_word,
                                                       input core_port_pkg::data_t new_word,
                                                       input core_port_pkg::strb_t strb);
    core_port_pkg::data_t res;
    res = old_word;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic core_port_pkg::desc_t rand_desc();
    // Top bit clear keeps it apart from the reset marker
    return {8'($random(seed)) & 8'h7F, 24'($random(seed)), 32'($random(seed))};
  endfunction

  ////////////////////////////////////////
  // Memory model and scoreboard
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (dmem.en && (dmem.wen != '0)) begin
      dmem_model[dmem.addr[6:3]] <= merge_bytes(dmem_model[dmem.addr[6:3]], dmem.wr_data,
                                                dmem.wen);
    end
    if (dmem.en && dmem.ren) begin
      rd_data <= dmem_model[dmem.addr[6:3]];
    end
  end

  task automatic check_desc(input core_port_pkg::desc_t got);
    core_port_pkg::desc_t want;
    if (exp_ctrl.size() + exp_core.size() == 0) begin
      errors++;
      $display("Send descriptor %h appeared with nothing queued", got);
    end else begin
      // Controller entries drain before any core entry
      want = (exp_ctrl.size() > 0) ? exp_ctrl.pop_front() : exp_core.pop_front();
      if (got !== want) begin
        errors++;
        $display("Mismatch desc_order: expected %h, actual %h", want, got);
      end
    end
  endtask

  task automatic check_read(input core_port_pkg::data_t got);
    core_port_pkg::data_t want;
    if (exp_rd.size() == 0) begin
      errors++;
      $display("Read response arrived with no read outstanding");
    end else begin
      want = exp_rd.pop_front();
      if (got !== want) begin
        errors++;
        $display("Mismatch dmem_readback: expected %h, actual %h", want, got);
      end
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (send_desc_valid && send_desc_ready) begin
        check_desc(send_desc);
      end
      if (rd_resp_valid && rd_resp_ready) begin
        check_read(rd_data);
      end
      if (wr_cmd.en && wr_ready && !wr_cmd.addr[15]) begin
        shadow[wr_cmd.addr[6:3]] = merge_bytes(shadow[wr_cmd.addr[6:3]], wr_cmd.data,
                                               wr_cmd.strb);
      end
      // Message from last cycle, 32 bits into the half chosen by bit 2
      if (msg_pend) begin
        shadow[msg_reg.addr[6:3]] = merge_bytes(shadow[msg_reg.addr[6:3]],
                                                64'(msg_reg.data) << (msg_reg.addr[2] * 32),
                                                8'(msg_reg.strb) << (msg_reg.addr[2] * 4));
      end
      if (rd_ready) begin
        exp_rd.push_back(shadow[rd_cmd.addr[6:3]]);
      end
    end
    msg_pend <= msg_in_valid && !rst;
    msg_reg  <= msg_in;
  end

  // Response back-pressure, random only during memory traffic
  always @(negedge clk) begin
    rd_resp_ready = resp_rand ? 1'($random(seed)) : 1'b1;
  end

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  task automatic push_ctrl(input core_port_pkg::desc_t d);
    int   t;
    logic is_cmd;
    is_cmd     = (d[63:56] == core_port_pkg::RESET_CMD_BYTE);
    ctrl_valid = 1'b1;
    ctrl_data  = d;
    t = 0;
    // A reset command acts without waiting for room in the queue
    while (!is_cmd && !ctrl_ready && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!is_cmd && !ctrl_ready) begin
      timeouts++;
      $display("Timeout: control word %h was never accepted", d);
    end else if (!is_cmd) begin
      exp_ctrl.push_back(d);
    end
    @(negedge clk);
    ctrl_valid = 1'b0;
  endtask

  task automatic push_core(input core_port_pkg::desc_t d);
    int t;
    core_desc_valid = 1'b1;
    core_desc       = d;
    t = 0;
    while (!core_desc_ready && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!core_desc_ready) begin
      timeouts++;
      $display("Timeout: core descriptor %h was never accepted", d);
    end else begin
      exp_core.push_back(d);
    end
    @(negedge clk);
    core_desc_valid = 1'b0;
  endtask

  // Ready is sampled at the rising edge, where inputs have settled
  task automatic dma_write(input core_port_pkg::addr_t addr, input logic last);
    int t;
    wr_cmd = '{en: 1'b1, addr: addr, data: {32'($random(seed)), 32'($random(seed))},
               strb: 8'($random(seed)), last: last};
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!wr_ready && t < TIMEOUT);
    if (!wr_ready) begin
      timeouts++;
      $display("Timeout: DMA write to %h was never accepted", addr);
    end
    @(negedge clk);
    wr_cmd.en = 1'b0;
  endtask

  task automatic dma_read(input core_port_pkg::addr_t addr, input logic last);
    int t;
    rd_cmd = '{en: 1'b1, addr: addr, last: last};
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!rd_ready && t < TIMEOUT);
    if (!rd_ready) begin
      timeouts++;
      $display("Timeout: DMA read from %h was never accepted", addr);
    end
    @(negedge clk);
    rd_cmd.en = 1'b0;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int t;
    rst             = 1'b1;
    ctrl_valid      = 1'b0;
    ctrl_data       = '0;
    core_desc_valid = 1'b0;
    core_desc       = '0;
    send_desc_ready = 1'b0;
    msg_in          = '0;
    msg_in_valid    = 1'b0;
    wr_cmd          = '0;
    rd_cmd          = '0;
    rd_resp_ready   = 1'b1;
    for (int i = 0; i < 16; i++) begin
      dmem_model[i] = fill_word(i);
      shadow[i]     = fill_word(i);
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // Controller words first so the stalled head never changes
    push_ctrl({core_port_pkg::RESET_CMD_BYTE, 56'd0});
    for (int i = 0; i < core_port_pkg::DESC_FIFO_DEPTH; i++) begin
      push_ctrl(rand_desc());
      if (i == 2) begin
        push_ctrl({core_port_pkg::RESET_CMD_BYTE, 55'd0, 1'b1});
      end
    end
    // Full controller queue does not stop a reset command
    push_ctrl({core_port_pkg::RESET_CMD_BYTE, 56'd0});
    for (int i = 0; i < core_port_pkg::DESC_FIFO_DEPTH; i++) begin
      push_core(rand_desc());
    end
    // Both queues hold DEPTH entries and refuse more
    if (ctrl_ready !== 1'b0 || core_desc_ready !== 1'b0) begin
      errors++;
      $display("Mismatch queue_full: expected 00, actual %b%b", ctrl_ready,
               core_desc_ready);
    end

    // Drain with random stalls, inputs quiet
    t = 0;
    while ((exp_ctrl.size() + exp_core.size()) > 0 && t < TIMEOUT) begin
      @(negedge clk);
      send_desc_ready = 1'($random(seed));
      t++;
    end
    if ((exp_ctrl.size() + exp_core.size()) > 0) begin
      timeouts++;
      $display("Timeout: send descriptors were not all delivered");
    end
    @(negedge clk);
    send_desc_ready = 1'b0;

    // Concurrent DMA writes, reads and broadcast messages
    resp_rand = 1'b1;
    fork
      begin : write_stream
        for (int i = 0; i < 24; i++) begin
          if (i % 4 == 3) begin
            dma_write({1'b1, 15'($random(seed))}, 1'b0);
          end else begin
            dma_write({9'd0, 4'($random(seed)), 3'd0}, (i % 4) == 2);
          end
        end
      end
      begin : read_stream
        // Odd reads set bit 15, which still means DMEM for a read
        for (int j = 0; j < 24; j++) begin
          dma_read({1'(j % 2), 8'd0, 4'($random(seed)), 3'd0}, (j % 4) == 3);
        end
      end
      begin : msg_stream
        for (int k = 0; k < 8; k++) begin
          repeat (3 + (k % 3) * 2) @(negedge clk);
          msg_in = '{strb: 4'($random(seed)), addr: 15'($random(seed)) & 15'h7F,
                     data: 32'($random(seed))};
          msg_in_valid = 1'b1;
          @(negedge clk);
          msg_in_valid = 1'b0;
        end
      end
    join
    resp_rand = 1'b0;

    t = 0;
    while (exp_rd.size() > 0 && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (exp_rd.size() > 0) begin
      timeouts++;
      $display("Timeout: read responses still outstanding at the end");
    end
    repeat (2) @(negedge clk);

    $display("Error counts: %0d check errors, %0d timeouts, %0d assertion failures",
             errors, timeouts, u_dut.u_assert.fail_count);
    if (errors + timeouts + u_dut.u_assert.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: flist.f
rtl/core_port_pkg.sv
rtl/desc_fifo.sv
rtl/ctrl_ingress.sv
rtl/send_desc_arbiter.sv
rtl/bcast_msg_writer.sv
rtl/dmem_arbiter.sv
rtl/core_port_top.sv
dv/core_port_assert.sv
dv/tb_core_port.sv

// File: rtl/bcast_msg_writer.sv
////////////////////////////////////////
// Broadcast message register and 64-bit
// strobed write conversion
////////////////////////////////////////
`timescale 1ns/1ps

module bcast_msg_writer (
  input  logic                      clk,
  input  logic                      rst,
  input  core_port_pkg::core_msg_t  msg_in,
  input  logic                      msg_in_valid,
  output logic                      msg_wr_valid,
  output core_port_pkg::dmem_addr_t msg_wr_addr,
  output core_port_pkg::strb_t      msg_wr_mask,
  output core_port_pkg::data_t      msg_wr_data
);

  logic [3:0]  msg_strb_r;
  logic [31:0] msg_data_r;
  logic        upper_half;

  // Payload, sampled every cycle
  always_ff @(posedge clk) begin
    msg_wr_addr <= msg_in.addr;
    msg_strb_r  <= msg_in.strb;
    msg_data_r  <= msg_in.data;
  end

  // Pulse valid, one cycle behind the input
  always_ff @(posedge clk) begin
    if (rst) begin
      msg_wr_valid <= 1'b0;
    end else begin
      msg_wr_valid <= msg_in_valid;
    end
  end

  // Address bit 2 picks the 32-bit half of the 64-bit word
  assign upper_half = msg_wr_addr[2];

  // Shift strobe by four lanes and data by 32 bits for the upper half
  assign msg_wr_mask = upper_half ? {msg_strb_r, 4'd0} : {4'd0, msg_strb_r};
  assign msg_wr_data = upper_half ? {msg_data_r, 32'd0} : {32'd0, msg_data_r};

endmodule

// File: rtl/core_port_pkg.sv
////////////////////////////////////////
// Shared widths, vector types, command structs
// and the DMEM operation encoding
////////////////////////////////////////
package core_port_pkg;

  // DMA word and address widths
  localparam int DATA_WIDTH      = 64;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int ADDR_WIDTH      = 16;
  // 32 KiB of DMEM, byte addressed
  localparam int DMEM_ADDR_WIDTH = 15;
  localparam int DESC_FIFO_DEPTH = 8;
  // Top byte of a control word that marks a core reset command
  localparam logic [7:0] RESET_CMD_BYTE = 8'hFF;
  // 1 alternates reads and writes, 0 switches only at the end of a burst
  localparam bit INTERLEAVE = 1'b1;

  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [STRB_WIDTH-1:0]      strb_t;
  typedef logic [ADDR_WIDTH-1:0]      addr_t;
  typedef logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_t;
  typedef logic [63:0]                desc_t;

  // Broadcast message from another core, 51 bits
  typedef struct packed {
    logic [3:0]  strb;
    dmem_addr_t  addr;
    logic [31:0] data;
  } core_msg_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
    strb_t strb;
    logic  last;
  } mem_wr_cmd_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
    logic  last;
  } mem_rd_cmd_t;

  // Second port of the core DMEM
  typedef struct packed {
    logic  en;
    logic  ren;
    strb_t wen;
    addr_t addr;
    data_t wr_data;
  } dmem_port_t;

  // Write-only port of the core IMEM
  typedef struct packed {
    strb_t wen;
    addr_t addr;
    data_t wr_data;
  } imem_port_t;

  // WRITE and READ are bitwise inverses of each other
  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    WRITE = 2'b01,
    READ  = 2'b10
  } dmem_op_e;

endpackage

// File: rtl/core_port_top.sv
////////////////////////////////////////
// Memory and control glue between the
// packet DMA engine and one core
////////////////////////////////////////
`timescale 1ns/1ps

module core_port_top (
  input  logic                       clk,
  input  logic                       rst,
  // Control input and core reset
  input  logic                       ctrl_valid,
  input  core_port_pkg::desc_t       ctrl_data,
  output logic                       ctrl_ready,
  output logic                       core_reset,
  // Descriptors from the core
  input  logic                       core_desc_valid,
  input  core_port_pkg::desc_t       core_desc,
  output logic                       core_desc_ready,
  // Send descriptors to the DMA engine
  output logic                       send_desc_valid,
  output core_port_pkg::desc_t       send_desc,
  input  logic                       send_desc_ready,
  // Broadcast messages
  input  core_port_pkg::core_msg_t   msg_in,
  input  logic                       msg_in_valid,
  // DMA memory commands
  input  core_port_pkg::mem_wr_cmd_t wr_cmd,
  output logic                       wr_ready,
  input  core_port_pkg::mem_rd_cmd_t rd_cmd,
  output logic                       rd_ready,
  output logic                       rd_resp_valid,
  input  logic                       rd_resp_ready,
  // Memory ports
  output core_port_pkg::dmem_port_t  dmem,
  output core_port_pkg::imem_port_t  imem
);

  logic                      ctrl_q_valid;
  core_port_pkg::desc_t      ctrl_q_desc;
  logic                      ctrl_q_ready;
  logic                      msg_wr_valid;
  core_port_pkg::dmem_addr_t msg_wr_addr;
  core_port_pkg::strb_t      msg_wr_mask;
  core_port_pkg::data_t      msg_wr_data;

  ////////////////////////////////////////
  // Descriptor path
  ////////////////////////////////////////

  ctrl_ingress u_ctrl_ingress (
    .clk        (clk),
    .rst        (rst),
    .ctrl_valid (ctrl_valid),
    .ctrl_data  (ctrl_data),
    .ctrl_ready (ctrl_ready),
    .core_reset (core_reset),
    .q_valid    (ctrl_q_valid),
    .q_desc     (ctrl_q_desc),
    .q_ready    (ctrl_q_ready)
  );

  send_desc_arbiter u_send_desc_arbiter (
    .clk             (clk),
    .rst             (rst),
    .ctrl_valid      (ctrl_q_valid),
    .ctrl_desc       (ctrl_q_desc),
    .ctrl_ready      (ctrl_q_ready),
    .core_desc_valid (core_desc_valid),
    .core_desc       (core_desc),
    .core_desc_ready (core_desc_ready),
    .send_desc_valid (send_desc_valid),
    .send_desc       (send_desc),
    .send_desc_ready (send_desc_ready)
  );

  ////////////////////////////////////////
  // Memory path
  ////////////////////////////////////////

  bcast_msg_writer u_bcast_msg_writer (
    .clk          (clk),
    .rst          (rst),
    .msg_in       (msg_in),
    .msg_in_valid (msg_in_valid),
    .msg_wr_valid (msg_wr_valid),
    .msg_wr_addr  (msg_wr_addr),
    .msg_wr_mask  (msg_wr_mask),
    .msg_wr_data  (msg_wr_data)
  );

  dmem_arbiter u_dmem_arbiter (
    .clk           (clk),
    .rst           (rst),
    .wr_cmd        (wr_cmd),
    .wr_ready      (wr_ready),
    .rd_cmd        (rd_cmd),
    .rd_ready      (rd_ready),
    .rd_resp_valid (rd_resp_valid),
    .rd_resp_ready (rd_resp_ready),
    .msg_wr_valid  (msg_wr_valid),
    .msg_wr_addr   (msg_wr_addr),
    .msg_wr_mask   (msg_wr_mask),
    .msg_wr_data   (msg_wr_data),
    .dmem          (dmem),
    .imem          (imem)
  );

endmodule

// File: rtl/ctrl_ingress.sv
////////////////////////////////////////
// Control input, core reset command decode
// and controller descriptor queue
////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_ingress (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ctrl_valid,
  input  core_port_pkg::desc_t ctrl_data,
  output logic                 ctrl_ready,
  output logic                 core_reset,
  output logic                 q_valid,
  output core_port_pkg::desc_t q_desc,
  input  logic                 q_ready
);

  logic reset_cmd;

  ////////////////////////////////////////
  // Reset command
  ////////////////////////////////////////

  // Top byte all ones, acts regardless of ready
  assign reset_cmd = ctrl_valid && (ctrl_data[63:56] == core_port_pkg::RESET_CMD_BYTE);

  // Core held in reset until a command releases it
  always_ff @(posedge clk) begin
    if (rst) begin
      core_reset <= 1'b1;
    end else if (reset_cmd) begin
      core_reset <= ctrl_data[0];
    end
  end

  ////////////////////////////////////////
  // Descriptor queue
  ////////////////////////////////////////

  // Reset commands never enter the queue
  desc_fifo #(
    .DEPTH (core_port_pkg::DESC_FIFO_DEPTH)
  ) u_ctrl_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (ctrl_valid && !reset_cmd),
    .in_data   (ctrl_data),
    .in_ready  (ctrl_ready),
    .out_valid (q_valid),
    .out_data  (q_desc),
    .out_ready (q_ready)
  );

endmodule

// File: rtl/desc_fifo.sv
////////////////////////////////////////
// Synchronous descriptor FIFO, valid/ready
////////////////////////////////////////
`timescale 1ns/1ps

module desc_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  core_port_pkg::desc_t in_data,
  output logic                 in_ready,
  output logic                 out_valid,
  output core_port_pkg::desc_t out_data,
  input  logic                 out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  core_port_pkg::desc_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Accept while there is room, present while not empty
  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Storage array
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap at DEPTH, count tracks occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/dmem_arbiter.sv
////////////////////////////////////////
// IMEM/DMEM address split, DMEM arbiter
// and read-response tracking
////////////////////////////////////////
`timescale 1ns/1ps

module dmem_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  core_port_pkg::mem_wr_cmd_t wr_cmd,
  output logic                       wr_ready,
  input  core_port_pkg::mem_rd_cmd_t rd_cmd,
  output logic                       rd_ready,
  output logic                       rd_resp_valid,
  input  logic                       rd_resp_ready,
  input  logic                       msg_wr_valid,
  input  core_port_pkg::dmem_addr_t  msg_wr_addr,
  input  core_port_pkg::strb_t       msg_wr_mask,
  input  core_port_pkg::data_t       msg_wr_data,
  output core_port_pkg::dmem_port_t  dmem,
  output core_port_pkg::imem_port_t  imem
);

  localparam int AW = core_port_pkg::ADDR_WIDTH;

  logic                    read_reject;
  logic                    imem_wr_en;
  logic                    dmem_wr_en;
  logic                    dmem_rd_en;
  core_port_pkg::dmem_op_e dmem_op;
  core_port_pkg::dmem_op_e dmem_last_op;
  logic                    dmem_switch;
  logic                    read_accepted_r;
  logic                    read_rejected;

  ////////////////////////////////////////
  // Address split
  ////////////////////////////////////////

  // Response pending but not taken blocks new reads
  assign read_reject = rd_resp_valid && !rd_resp_ready;

  // Top address bit selects IMEM for writes
  assign imem_wr_en = wr_cmd.en && wr_cmd.addr[AW-1];
  assign dmem_wr_en = wr_cmd.en && !wr_cmd.addr[AW-1];
  assign dmem_rd_en = rd_cmd.en && !read_reject;

  ////////////////////////////////////////
  // DMEM operation select
  ////////////////////////////////////////

  // Previous op, and a flag for a burst that ended with last
  always_ff @(posedge clk) begin
    if (rst) begin
      dmem_last_op <= core_port_pkg::IDLE;
      dmem_switch  <= 1'b0;
    end else begin
      dmem_last_op <= dmem_op;
      dmem_switch  <= ((dmem_op == core_port_pkg::READ) && rd_cmd.last && dmem_rd_en) ||
                      ((dmem_op == core_port_pkg::WRITE) && wr_cmd.last && dmem_wr_en);
    end
  end

  always_comb begin
    // Message write owns the port this cycle
    if (msg_wr_valid) begin
      dmem_op = core_port_pkg::IDLE;
    end else begin
      case ({dmem_wr_en, dmem_rd_en})
        2'b01:   dmem_op = core_port_pkg::READ;
        2'b10:   dmem_op = core_port_pkg::WRITE;
        2'b11: begin
          if (core_port_pkg::INTERLEAVE || dmem_switch) begin
            // After an idle cycle start with the write
            if (dmem_last_op == core_port_pkg::IDLE) begin
              dmem_op = core_port_pkg::WRITE;
            end else begin
              dmem_op = core_port_pkg::dmem_op_e'(~dmem_last_op);
            end
          end else begin
            dmem_op = dmem_last_op;
          end
        end
        default: dmem_op = core_port_pkg::IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Memory ports
  ////////////////////////////////////////

  always_comb begin
    dmem.en  = msg_wr_valid || (dmem_op != core_port_pkg::IDLE);
    dmem.ren = (dmem_op == core_port_pkg::READ);
    if (msg_wr_valid) begin
      dmem.wen     = msg_wr_mask;
      dmem.addr    = AW'(msg_wr_addr);
      dmem.wr_data = msg_wr_data;
    end else begin
      dmem.wen     = (dmem_op == core_port_pkg::WRITE) ? wr_cmd.strb : '0;
      // Bit 15 is only the IMEM select, the memory never sees it
      dmem.addr    = (dmem_op == core_port_pkg::WRITE) ? {1'b0, wr_cmd.addr[AW-2:0]}
                                                       : {1'b0, rd_cmd.addr[AW-2:0]};
      dmem.wr_data = wr_cmd.data;
    end
  end

  // IMEM writes never wait
  assign imem.wen     = imem_wr_en ? wr_cmd.strb : '0;
  assign imem.addr    = {1'b0, wr_cmd.addr[AW-2:0]};
  assign imem.wr_data = wr_cmd.data;

  ////////////////////////////////////////
  // Ready and read response
  ////////////////////////////////////////

  // Memory data arrives one cycle after ren, a reject holds it
  always_ff @(posedge clk) begin
    if (rst) begin
      read_accepted_r <= 1'b0;
      read_rejected   <= 1'b0;
    end else begin
      read_accepted_r <= (dmem_op == core_port_pkg::READ);
      read_rejected   <= read_reject;
    end
  end

  assign rd_resp_valid = read_accepted_r || read_rejected;

  // Ready means accepted in this cycle
  assign wr_ready = !(dmem_wr_en && (dmem_op != core_port_pkg::WRITE));
  assign rd_ready = (dmem_op == core_port_pkg::READ);

endmodule

// File: rtl/send_desc_arbiter.sv
////////////////////////////////////////
// Core descriptor queue and fixed-priority
// send-descriptor arbiter
////////////////////////////////////////
`timescale 1ns/1ps

module send_desc_arbiter (
  input  logic                 clk,
  input  logic                 rst,
  // Controller queue output
  input  logic                 ctrl_valid,
  input  core_port_pkg::desc_t ctrl_desc,
  output logic                 ctrl_ready,
  // Descriptors from the core
  input  logic                 core_desc_valid,
  input  core_port_pkg::desc_t core_desc,
  output logic                 core_desc_ready,
  // Toward the DMA engine
  output logic                 send_desc_valid,
  output core_port_pkg::desc_t send_desc,
  input  logic                 send_desc_ready
);

  logic                 core_q_valid;
  core_port_pkg::desc_t core_q_desc;
  logic                 core_q_ready;
  logic                 ctrl_select;

  ////////////////////////////////////////
  // Core descriptor queue
  ////////////////////////////////////////

  desc_fifo #(
    .DEPTH (core_port_pkg::DESC_FIFO_DEPTH)
  ) u_core_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (core_desc_valid),
    .in_data   (core_desc),
    .in_ready  (core_desc_ready),
    .out_valid (core_q_valid),
    .out_data  (core_q_desc),
    .out_ready (core_q_ready)
  );

  ////////////////////////////////////////
  // Arbiter
  ////////////////////////////////////////

  // Controller wins whenever its queue holds an entry
  assign ctrl_select = ctrl_valid;

  assign send_desc_valid = ctrl_valid || core_q_valid;
  assign send_desc       = ctrl_select ? ctrl_desc : core_q_desc;

  // Pop only the selected queue, so a stalled output holds still
  assign ctrl_ready   = send_desc_ready && ctrl_select;
  assign core_q_ready = send_desc_ready && !ctrl_select;

endmodule
